//--- logic/cmdrsp_pkg.sv
// Command/response bus widths and records; imported by the router, its targets and the top
package cmdrsp_pkg;

        // ==============================
        // Bus widths
        // ==============================
        parameter int ADDR_WIDTH = 12;
        parameter int DATA_WIDTH = 32;

        // ==============================
        // Transaction records
        // ==============================

        // Command from the bus side, 45 bits
        typedef struct packed {
                logic                  pwrite;
                logic [ADDR_WIDTH-1:0] paddr;
                logic [DATA_WIDTH-1:0] pwdata;
        } cmd_req_t;

        // Response back to the bus side
        typedef struct packed {
                logic [DATA_WIDTH-1:0] prdata;
                logic                  pslverr;
        } cmd_rsp_t;

endpackage

//--- logic/perf_pkg.sv
// Profiler event and config records plus register offsets; used by the router and capture side
package perf_pkg;

        // Number of event channels feeding the capture stage
        parameter int NUM_CHANNELS = 8;

        // One captured event as stored in the FIFO
        typedef struct packed {
                logic [31:0] stamp;
                logic        event_kind;
                logic [2:0]  channel_id;
        } perf_event_t;

        // PERF_CONFIG bits, clear is bit 2 and enable is bit 0
        // Mode 0 stamps free-running time, mode 1 stamps time since the last event
        typedef struct packed {
                logic clear;
                logic mode;
                logic enable;
        } perf_cfg_t;

        // Byte offsets inside the 0x040-0x0FF window
        parameter logic [7:0] PERF_CONFIG_OFS    = 8'h40;
        parameter logic [7:0] PERF_DATA_LOW_OFS  = 8'h44;
        parameter logic [7:0] PERF_DATA_HIGH_OFS = 8'h48;
        parameter logic [7:0] PERF_STATUS_OFS    = 8'h4C;

        // Read value for a hole in the profiler window
        parameter logic [31:0] PERF_BAD_READ = 32'hDEADBEEF;

endpackage

//--- logic/perf_event_capture.sv
// Profiler producer; turns channel strobes into timestamped records for the event FIFO
`timescale 1ns/1ns

module perf_event_capture import perf_pkg::*; (
        input  logic                    clk,
        input  logic                    rst_n,
        input  perf_cfg_t               cfg,
        input  logic [NUM_CHANNELS-1:0] evt_strobe,
        input  logic                    evt_kind,
        output logic                    push,
        output perf_event_t             event_out
);

        logic [31:0] time_cnt;
        logic [31:0] last_time;
        logic [2:0]  chan;

        // Free-running time base and time of the previous captured event
        // Clear restarts both so mode 1 measures from zero again
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        time_cnt  <= '0;
                        last_time <= '0;
                end else if (cfg.clear) begin
                        time_cnt  <= '0;
                        last_time <= '0;
                end else begin
                        time_cnt <= time_cnt + 32'd1;
                        if (push) begin
                                last_time <= time_cnt;
                        end
                end
        end

        // Lowest-numbered strobing channel wins, scan from the top down
        always_comb begin
                chan = '0;
                for (int i = NUM_CHANNELS - 1; i >= 0; i--) begin
                        if (evt_strobe[i]) begin
                                chan = 3'(i);
                        end
                end
        end

        // Record goes out in the strobe cycle, FIFO takes it on the next edge
        assign push = cfg.enable && (|evt_strobe);

        assign event_out.stamp      = cfg.mode ? (time_cnt - last_time) : time_cnt;
        assign event_out.event_kind = evt_kind;
        assign event_out.channel_id = chan;

endmodule

//--- logic/perf_fifo.sv
// Synchronous FIFO for any payload type; buffers profiler events between capture and router
`timescale 1ns/1ns

module perf_fifo #(
        parameter type payload_t  = logic [31:0],
        parameter int  FIFO_DEPTH = 16
) (
        input  logic        clk,
        input  logic        rst_n,
        input  logic        flush,
        input  logic        push,
        input  payload_t    push_data,
        input  logic        pop,
        output payload_t    head,
        output logic [15:0] count,
        output logic        full,
        output logic        empty
);

        localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

        payload_t         mem [FIFO_DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic             do_push;
        logic             do_pop;

        // Pointer advance with wrap, depth need not be a power of two
        function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
                return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
        endfunction

        // Push into a full buffer or pop from an empty one is dropped
        assign do_push = push && !full && !flush;
        assign do_pop  = pop && !empty && !flush;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else if (flush) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (do_push) wr_ptr <= next_ptr(wr_ptr);
                        if (do_pop) rd_ptr <= next_ptr(rd_ptr);
                        // Simultaneous push and pop leaves the count alone
                        case ({do_push, do_pop})
                                2'b10:   count <= count + 16'd1;
                                2'b01:   count <= count - 16'd1;
                                default: count <= count;
                        endcase
                end
        end

        // Storage
        always_ff @(posedge clk) begin
                if (do_push) begin
                        mem[wr_ptr] <= push_data;
                end
        end

        assign head  = mem[rd_ptr];
        assign full  = (count == 16'(FIFO_DEPTH));
        assign empty = (count == 16'd0);

endmodule

//--- logic/cmdrsp_router.sv
// Address router for the command port; owns the profiler registers and pops the event FIFO
`timescale 1ns/1ns

module cmdrsp_router import cmdrsp_pkg::*, perf_pkg::*; (
        input  logic        clk,
        input  logic        rst_n,
        // Upstream command/response port
        input  logic        s_cmd_valid,
        output logic        s_cmd_ready,
        input  cmd_req_t    s_cmd,
        output logic        s_rsp_valid,
        input  logic        s_rsp_ready,
        output cmd_rsp_t    s_rsp,
        // Descriptor kick-off target m0 at 0x000-0x03F
        output logic        m0_cmd_valid,
        input  logic        m0_cmd_ready,
        output cmd_req_t    m0_cmd,
        input  logic        m0_rsp_valid,
        output logic        m0_rsp_ready,
        input  cmd_rsp_t    m0_rsp,
        // Config registers on m1 take everything not decoded elsewhere
        output logic        m1_cmd_valid,
        input  logic        m1_cmd_ready,
        output cmd_req_t    m1_cmd,
        input  logic        m1_rsp_valid,
        output logic        m1_rsp_ready,
        input  cmd_rsp_t    m1_rsp,
        // Profiler side
        output perf_cfg_t   cfg,
        output logic        perf_fifo_rd,
        input  perf_event_t fifo_head,
        input  logic [15:0] fifo_count,
        input  logic        fifo_full,
        input  logic        fifo_empty
);

        // ==============================
        // Address decode
        // ==============================
        logic hit_m0;
        logic hit_perf;
        logic hit_m1;
        logic busy;
        logic accept;

        assign hit_m0   = (s_cmd.paddr[ADDR_WIDTH-1:6] == '0);
        assign hit_perf = (s_cmd.paddr[ADDR_WIDTH-1:8] == '0) && (s_cmd.paddr[7:6] != 2'b00);
        assign hit_m1   = !hit_m0 && !hit_perf;

        // ==============================
        // Response ownership
        // ==============================
        logic sel_m0;
        logic sel_perf;
        logic sel_m1;

        // Hold off new commands while a response is owed
        assign busy   = sel_m0 || sel_perf || sel_m1;
        assign accept = s_cmd_valid && s_cmd_ready;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        sel_m0   <= 1'b0;
                        sel_perf <= 1'b0;
                        sel_m1   <= 1'b0;
                end else if (accept) begin
                        sel_m0   <= hit_m0;
                        sel_perf <= hit_perf;
                        sel_m1   <= hit_m1;
                end else if (s_rsp_valid && s_rsp_ready) begin
                        sel_m0   <= 1'b0;
                        sel_perf <= 1'b0;
                        sel_m1   <= 1'b0;
                end
        end

        // ==============================
        // Profiler registers
        // ==============================
        logic [DATA_WIDTH-1:0] perf_rdata;
        logic [DATA_WIDTH-1:0] perf_rdata_q;

        // The clear bit of a config write drops again one cycle later
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        cfg <= '0;
                end else if (accept && hit_perf && s_cmd.pwrite &&
                             s_cmd.paddr[7:0] == PERF_CONFIG_OFS) begin
                        cfg <= perf_cfg_t'(s_cmd.pwdata[2:0]);
                end else if (cfg.clear) begin
                        cfg.clear <= 1'b0;
                end
        end

        // Reading DATA_LOW consumes the head entry
        assign perf_fifo_rd = accept && hit_perf && !s_cmd.pwrite &&
                              (s_cmd.paddr[7:0] == PERF_DATA_LOW_OFS);

        always_comb begin
                case (s_cmd.paddr[7:0])
                        PERF_CONFIG_OFS:    perf_rdata = {29'd0, cfg};
                        PERF_DATA_LOW_OFS:  perf_rdata = fifo_head.stamp;
                        PERF_DATA_HIGH_OFS: perf_rdata = {28'd0, fifo_head.event_kind,
                                                          fifo_head.channel_id};
                        PERF_STATUS_OFS:    perf_rdata = {fifo_count, 14'd0,
                                                          fifo_full, fifo_empty};
                        default:            perf_rdata = PERF_BAD_READ;
                endcase
        end

        // Sampled at accept so the data holds under back-pressure
        always_ff @(posedge clk) begin
                if (accept && hit_perf) begin
                        perf_rdata_q <= perf_rdata;
                end
        end

        // ==============================
        // Command and response steering
        // ==============================
        assign m0_cmd       = s_cmd;
        assign m1_cmd       = s_cmd;
        assign m0_cmd_valid = s_cmd_valid && hit_m0 && !busy;
        assign m1_cmd_valid = s_cmd_valid && hit_m1 && !busy;

        // Profiler is always able to take a command
        assign s_cmd_ready = !busy && (hit_m0 ? m0_cmd_ready : (hit_perf || m1_cmd_ready));

        // Profiler response is valid as soon as its selection is registered
        assign s_rsp_valid = sel_perf || (sel_m0 && m0_rsp_valid) || (sel_m1 && m1_rsp_valid);

        assign s_rsp = sel_m0   ? m0_rsp :
                       sel_perf ? cmd_rsp_t'{prdata: perf_rdata_q, pslverr: 1'b0} :
                       m1_rsp;

        assign m0_rsp_ready = sel_m0 && s_rsp_ready;
        assign m1_rsp_ready = sel_m1 && s_rsp_ready;

endmodule

//--- logic/descr_kick.sv
// Descriptor kick-off target; stores a descriptor address and pulses a kick on command
`timescale 1ns/1ns

module descr_kick import cmdrsp_pkg::*; (
        input  logic                  clk,
        input  logic                  rst_n,
        input  logic                  cmd_valid,
        output logic                  cmd_ready,
        input  cmd_req_t              cmd,
        output logic                  rsp_valid,
        input  logic                  rsp_ready,
        output cmd_rsp_t              rsp,
        output logic                  kick_valid,
        output logic [DATA_WIDTH-1:0] kick_addr
);

        logic [DATA_WIDTH-1:0] desc_addr;
        logic                  accept;
        logic                  ofs_addr;
        logic                  ofs_kick;

        assign accept    = cmd_valid && cmd_ready;
        assign cmd_ready = !rsp_valid;
        // 0x00 descriptor address, 0x04 kick strobe
        assign ofs_addr  = (cmd.paddr[5:0] == 6'h00);
        assign ofs_kick  = (cmd.paddr[5:0] == 6'h04);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        rsp_valid  <= 1'b0;
                        kick_valid <= 1'b0;
                end else begin
                        // Single-cycle pulse on a write of bit 0 to the kick offset
                        kick_valid <= accept && cmd.pwrite && ofs_kick && cmd.pwdata[0];
                        if (accept) rsp_valid <= 1'b1;
                        else if (rsp_ready) rsp_valid <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (accept) begin
                        if (cmd.pwrite && ofs_addr) desc_addr <= cmd.pwdata;
                        rsp.prdata  <= (!cmd.pwrite && ofs_addr) ? desc_addr : '0;
                        rsp.pslverr <= !(ofs_addr || ofs_kick);
                end
        end

        assign kick_addr = desc_addr;

endmodule

//--- logic/config_regs.sv
// Default-route config register file; word registers from 0x100, errors outside that range
`timescale 1ns/1ns

module config_regs import cmdrsp_pkg::*; #(
        parameter int NUM_REGS = 16
) (
        input  logic                  clk,
        input  logic                  rst_n,
        input  logic                  cmd_valid,
        output logic                  cmd_ready,
        input  cmd_req_t              cmd,
        output logic                  rsp_valid,
        input  logic                  rsp_ready,
        output cmd_rsp_t              rsp,
        output logic [DATA_WIDTH-1:0] ctrl_word
);

        localparam int                    IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;
        localparam logic [ADDR_WIDTH-1:0] BASE  = ADDR_WIDTH'(12'h100);

        logic [DATA_WIDTH-1:0] regs [NUM_REGS];
        logic [ADDR_WIDTH-1:0] rel;
        logic [IDX_W-1:0]      idx;
        logic                  in_range;
        logic                  accept;

        // Word index relative to the base, low address bits ignored
        assign rel      = cmd.paddr - BASE;
        assign idx      = rel[IDX_W+1:2];
        assign in_range = (cmd.paddr >= BASE) && (rel[ADDR_WIDTH-1:2] < NUM_REGS);
        assign accept   = cmd_valid && cmd_ready;
        assign cmd_ready = !rsp_valid;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        rsp_valid <= 1'b0;
                        for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
                end else begin
                        if (accept && cmd.pwrite && in_range) regs[idx] <= cmd.pwdata;
                        if (accept) rsp_valid <= 1'b1;
                        else if (rsp_ready) rsp_valid <= 1'b0;
                end
        end

        // Out-of-range access reads as zero with an error
        always_ff @(posedge clk) begin
                if (accept) begin
                        rsp.prdata  <= (!cmd.pwrite && in_range) ? regs[idx] : '0;
                        rsp.pslverr <= !in_range;
                end
        end

        assign ctrl_word = regs[0];

endmodule

//--- logic/cmd_fabric.sv
// Top level of the register-access fabric; connects router, targets and profiler pipeline
`timescale 1ns/1ns

module cmd_fabric import cmdrsp_pkg::*, perf_pkg::*; #(
        parameter int FIFO_DEPTH = 16,
        parameter int NUM_REGS   = 16
) (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    cmd_valid,
        output logic                    cmd_ready,
        input  cmd_req_t                cmd,
        output logic                    rsp_valid,
        input  logic                    rsp_ready,
        output cmd_rsp_t                rsp,
        input  logic [NUM_CHANNELS-1:0] evt_strobe,
        input  logic                    evt_kind,
        output logic                    kick_valid,
        output logic [DATA_WIDTH-1:0]   kick_addr,
        output logic [DATA_WIDTH-1:0]   ctrl_word
);

        // Router to target links
        logic        m0_cmd_valid, m0_cmd_ready, m0_rsp_valid, m0_rsp_ready;
        logic        m1_cmd_valid, m1_cmd_ready, m1_rsp_valid, m1_rsp_ready;
        cmd_req_t    m0_cmd, m1_cmd;
        cmd_rsp_t    m0_rsp, m1_rsp;

        // Profiler pipeline
        perf_cfg_t   cfg;
        perf_event_t evt, fifo_head;
        logic        evt_push, fifo_rd, fifo_full, fifo_empty;
        logic [15:0] fifo_count;

        cmdrsp_router u_router (
                .clk(clk), .rst_n(rst_n),
                .s_cmd_valid(cmd_valid), .s_cmd_ready(cmd_ready), .s_cmd(cmd),
                .s_rsp_valid(rsp_valid), .s_rsp_ready(rsp_ready), .s_rsp(rsp),
                .m0_cmd_valid(m0_cmd_valid), .m0_cmd_ready(m0_cmd_ready), .m0_cmd(m0_cmd),
                .m0_rsp_valid(m0_rsp_valid), .m0_rsp_ready(m0_rsp_ready), .m0_rsp(m0_rsp),
                .m1_cmd_valid(m1_cmd_valid), .m1_cmd_ready(m1_cmd_ready), .m1_cmd(m1_cmd),
                .m1_rsp_valid(m1_rsp_valid), .m1_rsp_ready(m1_rsp_ready), .m1_rsp(m1_rsp),
                .cfg(cfg), .perf_fifo_rd(fifo_rd), .fifo_head(fifo_head),
                .fifo_count(fifo_count), .fifo_full(fifo_full), .fifo_empty(fifo_empty)
        );

        descr_kick u_descr_kick (
                .clk(clk), .rst_n(rst_n),
                .cmd_valid(m0_cmd_valid), .cmd_ready(m0_cmd_ready), .cmd(m0_cmd),
                .rsp_valid(m0_rsp_valid), .rsp_ready(m0_rsp_ready), .rsp(m0_rsp),
                .kick_valid(kick_valid), .kick_addr(kick_addr)
        );

        config_regs #(.NUM_REGS(NUM_REGS)) u_config_regs (
                .clk(clk), .rst_n(rst_n),
                .cmd_valid(m1_cmd_valid), .cmd_ready(m1_cmd_ready), .cmd(m1_cmd),
                .rsp_valid(m1_rsp_valid), .rsp_ready(m1_rsp_ready), .rsp(m1_rsp),
                .ctrl_word(ctrl_word)
        );

        perf_event_capture u_capture (
                .clk(clk), .rst_n(rst_n), .cfg(cfg),
                .evt_strobe(evt_strobe), .evt_kind(evt_kind),
                .push(evt_push), .event_out(evt)
        );

        // Clear flushes the buffer in the same cycle it resets the time base
        perf_fifo #(.payload_t(perf_event_t), .FIFO_DEPTH(FIFO_DEPTH)) u_perf_fifo (
                .clk(clk), .rst_n(rst_n), .flush(cfg.clear),
                .push(evt_push), .push_data(evt), .pop(fifo_rd),
                .head(fifo_head), .count(fifo_count), .full(fifo_full), .empty(fifo_empty)
        );

endmodule

//--- testbench/cmd_fabric_tb.sv
// Directed testbench for the command fabric; built and run from the Makefile with Verilator
`timescale 1ns/1ns

module cmd_fabric_tb import cmdrsp_pkg::*, perf_pkg::*; ();

        localparam int FIFO_DEPTH   = 16;
        localparam int NUM_REGS     = 16;
        localparam int RESET_CYCLES = 10;
        // About 30 bus operations, each at most 8 cycles with the longest hold
        localparam int NUM_BUS_OPS    = 32;
        localparam int MAX_OP_CYCLES  = 8;
        localparam int TIMEOUT_CYCLES =
                2 * (RESET_CYCLES + NUM_BUS_OPS * MAX_OP_CYCLES + FIFO_DEPTH + 16);

        // Profiler register addresses
        localparam logic [11:0] ADDR_CONFIG    = 12'h040;
        localparam logic [11:0] ADDR_DATA_LOW  = 12'h044;
        localparam logic [11:0] ADDR_DATA_HIGH = 12'h048;
        localparam logic [11:0] ADDR_STATUS    = 12'h04C;

        logic                    clk;
        logic                    rst_n;
        logic                    cmd_valid;
        logic                    cmd_ready;
        cmd_req_t                cmd;
        logic                    rsp_valid;
        logic                    rsp_ready;
        cmd_rsp_t                rsp;
        logic [NUM_CHANNELS-1:0] evt_strobe;
        logic                    evt_kind;
        logic                    kick_valid;
        logic [31:0]             kick_addr;
        logic [31:0]             ctrl_word;

        integer      seed      = 32'h7cdd750c;
        int          cycle_cnt = 0;
        int          kick_cnt  = 0;
        logic [31:0] kick_seen;

        cmd_fabric #(.FIFO_DEPTH(FIFO_DEPTH), .NUM_REGS(NUM_REGS)) u_cmd_fabric (
                .clk(clk), .rst_n(rst_n),
                .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
                .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp),
                .evt_strobe(evt_strobe), .evt_kind(evt_kind),
                .kick_valid(kick_valid), .kick_addr(kick_addr), .ctrl_word(ctrl_word)
        );

        // ==============================
        // Clock, timeout, kick monitor
        // ==============================
        initial clk = 1'b0;
        always #20 clk = ~clk;

        always @(posedge clk) begin
                cycle_cnt <= cycle_cnt + 1;
                if (cycle_cnt >= TIMEOUT_CYCLES) begin
                        stop_run("run did not finish within the cycle limit");
                end
        end

        // Count kick pulses and keep the address seen with the last one
        always @(negedge clk) begin
                if (rst_n && kick_valid) begin
                        kick_cnt  <= kick_cnt + 1;
                        kick_seen <= kick_addr;
                end
        end

        // ==============================
        // Checks and bus helpers
        // ==============================
        task automatic stop_run(input string why);
                $display("ERROR: %s", why);
                $display("Test failed");
                $fatal(1, "stopped at first error");
        endtask

        task automatic check_val(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
                assert (got === exp) else begin
                        $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
                        stop_run("value mismatch");
                end
        endtask

        task automatic check_true(input logic cond, input string why);
                assert (cond) else stop_run(why);
        endtask

        // Random rsp_ready delay of 0 to 3 cycles
        function automatic int rand_hold();
                return int'($unsigned($random(seed)) % 4);
        endfunction

        // Starts and ends just after a falling edge; returns once accepted
        task automatic issue_cmd(input logic write, input logic [11:0] addr,
                                 input logic [31:0] data);
                cmd_valid  = 1'b1;
                cmd.pwrite = write;
                cmd.paddr  = addr;
                cmd.pwdata = data;
                #1;
                while (!cmd_ready) begin
                        @(negedge clk);
                        #1;
                end
                // Accepted on the coming rising edge
                @(negedge clk);
                cmd_valid = 1'b0;
        endtask

        // Response due one cycle after accept, held low for hold cycles
        task automatic take_rsp(input int hold, output cmd_rsp_t got);
                cmd_rsp_t first;
                check_true(rsp_valid, "no response one cycle after the command was accepted");
                first = rsp;
                repeat (hold) begin
                        @(negedge clk);
                        check_true(rsp_valid, "rsp_valid dropped while rsp_ready was low");
                        check_val("rsp.prdata", rsp.prdata, first.prdata);
                        check_val("rsp.pslverr", 32'(rsp.pslverr), 32'(first.pslverr));
                        check_true(!cmd_ready, "cmd_ready rose while a response was pending");
                end
                got       = rsp;
                rsp_ready = 1'b1;
                @(negedge clk);
                rsp_ready = 1'b0;
                check_true(!rsp_valid, "rsp_valid still high after the response was taken");
        endtask

        task automatic bus_write(input logic [11:0] addr, input logic [31:0] data);
                cmd_rsp_t r;
                issue_cmd(1'b1, addr, data);
                take_rsp(rand_hold(), r);
                check_val("rsp.pslverr", 32'(r.pslverr), 32'd0);
        endtask

        task automatic bus_read(input logic [11:0] addr, output cmd_rsp_t r);
                issue_cmd(1'b0, addr, 32'd0);
                take_rsp(rand_hold(), r);
        endtask

        task automatic pulse_strobe(input logic [7:0] mask, input logic kind);
                evt_strobe = mask;
                evt_kind   = kind;
                @(negedge clk);
                evt_strobe = '0;
                evt_kind   = 1'b0;
                @(negedge clk);
        endtask

        // ==============================
        // Directed tests
        // ==============================
        task automatic test_config_regs();
                logic [11:0] addrs [4];
                logic [31:0] vals  [4];
                cmd_rsp_t    r;
                addrs = '{12'h100, 12'h104, 12'h11C, 12'h13C};
                foreach (addrs[i]) begin
                        vals[i] = $random(seed);
                        bus_write(addrs[i], vals[i]);
                end
                foreach (addrs[i]) begin
                        bus_read(addrs[i], r);
                        check_val("rsp.prdata", r.prdata, vals[i]);
                        check_val("rsp.pslverr", 32'(r.pslverr), 32'd0);
                end
                check_val("ctrl_word", ctrl_word, vals[0]);
                // Beyond the last register
                bus_read(12'h200, r);
                check_val("rsp.pslverr", 32'(r.pslverr), 32'd1);
                check_val("rsp.prdata", r.prdata, 32'd0);
        endtask

        task automatic test_descr_kick();
                logic [31:0] desc;
                int          kicks_before;
                cmd_rsp_t    r;
                desc = $random(seed);
                bus_write(12'h000, desc);
                kicks_before = kick_cnt;
                bus_write(12'h004, 32'd1);
                // Let the pulse pass the monitor
                repeat (2) @(negedge clk);
                check_val("kick_valid pulses", 32'(kick_cnt - kicks_before), 32'd1);
                check_val("kick_addr", kick_seen, desc);
                bus_read(12'h000, r);
                check_val("rsp.prdata", r.prdata, desc);
                bus_read(12'h008, r);
                check_val("rsp.pslverr", 32'(r.pslverr), 32'd1);
        endtask

        task automatic test_perf_config();
                cmd_rsp_t r;
                // enable=1, mode=0
                bus_write(ADDR_CONFIG, 32'h1);
                bus_read(ADDR_CONFIG, r);
                check_val("PERF_CONFIG", r.prdata, 32'h1);
                // Hole in the profiler window
                bus_read(12'h050, r);
                check_val("rsp.prdata", r.prdata, 32'hDEAD_BEEF);
                check_val("rsp.pslverr", 32'(r.pslverr), 32'd0);
        endtask

        task automatic test_event_capture();
                logic [2:0]  exp_chan [3];
                logic        exp_kind [3];
                logic [31:0] prev_stamp;
                cmd_rsp_t    r;
                exp_chan   = '{3'd5, 3'd2, 3'd2};
                exp_kind   = '{1'b1, 1'b0, 1'b1};
                prev_stamp = '0;
                pulse_strobe(8'b0010_0000, 1'b1);
                pulse_strobe(8'b0000_0100, 1'b0);
                // Channels 2 and 6 together, lowest wins
                pulse_strobe(8'b0100_0100, 1'b1);
                // Status is count in the upper half, full bit 1, empty bit 0
                bus_read(ADDR_STATUS, r);
                check_val("PERF_STATUS", r.prdata, {16'd3, 16'd0});
                for (int i = 0; i < 3; i++) begin
                        // High word first, the low word read pops the entry
                        bus_read(ADDR_DATA_HIGH, r);
                        check_val("PERF_DATA_HIGH", r.prdata, {28'd0, exp_kind[i], exp_chan[i]});
                        bus_read(ADDR_DATA_LOW, r);
                        if (i > 0) begin
                                check_true(r.prdata > prev_stamp, "event stamps did not increase");
                        end
                        prev_stamp = r.prdata;
                end
                bus_read(ADDR_STATUS, r);
                check_val("PERF_STATUS", r.prdata, 32'h0000_0001);
        endtask

        task automatic test_overflow_clear();
                cmd_rsp_t r;
                evt_strobe = 8'h02;
                repeat (FIFO_DEPTH + 3) @(negedge clk);
                evt_strobe = '0;
                bus_read(ADDR_STATUS, r);
                check_val("PERF_STATUS", r.prdata, {16'(FIFO_DEPTH), 14'd0, 1'b1, 1'b0});
                // clear plus enable, clear drops by itself
                bus_write(ADDR_CONFIG, 32'h5);
                bus_read(ADDR_STATUS, r);
                check_val("PERF_STATUS", r.prdata, 32'h0000_0001);
                bus_read(ADDR_CONFIG, r);
                check_val("PERF_CONFIG", r.prdata, 32'h1);
        endtask

        task automatic test_back_pressure();
                logic [31:0] val;
                cmd_rsp_t    r;
                val = $random(seed);
                bus_write(12'h100, val);
                // Target path held for 6 cycles
                issue_cmd(1'b0, 12'h100, 32'd0);
                take_rsp(6, r);
                check_val("rsp.prdata", r.prdata, val);
                // Profiler path held for 5 cycles
                issue_cmd(1'b0, ADDR_CONFIG, 32'd0);
                take_rsp(5, r);
                check_val("PERF_CONFIG", r.prdata, 32'h1);
        endtask

        // ==============================
        // Main sequence
        // ==============================
        initial begin
                rst_n      = 1'b0;
                cmd_valid  = 1'b0;
                cmd        = '0;
                rsp_ready  = 1'b0;
                evt_strobe = '0;
                evt_kind   = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
                @(negedge clk);
                check_true(!rsp_valid && !kick_valid && cmd_ready,
                           "outputs not in their reset state");
                test_config_regs();
                test_descr_kick();
                test_perf_config();
                test_event_capture();
                test_overflow_clear();
                test_back_pressure();
                $display("Test passed");
                $finish;
        end

endmodule

//--- cmd_fabric.f
logic/cmdrsp_pkg.sv
logic/perf_pkg.sv
logic/perf_event_capture.sv
logic/perf_fifo.sv
logic/cmdrsp_router.sv
logic/descr_kick.sv
logic/config_regs.sv
logic/cmd_fabric.sv
testbench/cmd_fabric_tb.sv

//--- Makefile
TOP := cmd_fabric_tb

.PHONY: all run lint clean

all: run

# Build and run; a $fatal in the testbench gives a non-zero exit status
run:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f cmd_fabric.f
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module cmd_fabric -f cmd_fabric.f

clean:
	rm -rf obj_dir
